// File: design/stream_cfg_pkg.sv
// data-path constants shared by the memory port and the input stream
package stream_cfg_pkg;

  // byte address width of the shared memory port
  parameter int unsigned ADDR_WIDTH = 32;

endpackage

// File: design/sink_ctrl_pkg.sv
// control-plane types and address-pattern field widths for the stream sink
package sink_ctrl_pkg;

  // sink FSM states
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    WORKING = 2'b01,
    DRAIN   = 2'b10
  } sink_state_e;

  // stride fields are signed-agnostic byte offsets
  parameter int unsigned STRIDE_WIDTH = 32;

  // line length and total length, in words
  parameter int unsigned LEN_WIDTH = 16;

endpackage

// File: design/stream_fifo.sv
// circular-buffer valid/ready FIFO with synchronous clear
`timescale 1ns/10ps

module stream_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // occupancy only moves when exactly one side transfers
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

endmodule

// File: design/stream_addressgen.sv
// two-dimensional word address generator with a valid/ready address output
`timescale 1ns/10ps

module stream_addressgen import stream_cfg_pkg::*, sink_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    enable_i,
  input  logic                    start_i,
  input  logic [ADDR_WIDTH-1:0]   base_addr_i,
  input  logic [STRIDE_WIDTH-1:0] word_stride_i,
  input  logic [LEN_WIDTH-1:0]    line_length_i,
  input  logic [STRIDE_WIDTH-1:0] line_stride_i,
  input  logic [LEN_WIDTH-1:0]    tot_len_i,
  input  logic                    addr_ready_i,
  output logic [ADDR_WIDTH-1:0]   addr_o,
  output logic                    addr_valid_o,
  output logic                    done_o
);

  // sampled pattern
  logic [STRIDE_WIDTH-1:0] word_stride_q;
  logic [LEN_WIDTH-1:0]    line_length_q;
  logic [STRIDE_WIDTH-1:0] line_stride_q;
  logic [LEN_WIDTH-1:0]    tot_len_q;

  logic                  active_q;
  logic [LEN_WIDTH-1:0]  word_cnt_q;
  logic [LEN_WIDTH-1:0]  addr_cnt_q;
  logic [ADDR_WIDTH-1:0] line_addr_q;
  logic [ADDR_WIDTH-1:0] addr_q;

  logic                  load;
  logic                  accept;
  logic                  last_addr;
  logic                  line_wrap;
  logic [ADDR_WIDTH-1:0] next_line_addr;
  logic [ADDR_WIDTH-1:0] next_word_addr;

  assign load   = start_i & enable_i;
  assign accept = addr_valid_o & addr_ready_i;

  assign last_addr = (addr_cnt_q == tot_len_q - LEN_WIDTH'(1));
  assign line_wrap = (word_cnt_q == line_length_q - LEN_WIDTH'(1));

  assign next_line_addr = line_addr_q + ADDR_WIDTH'(line_stride_q);
  assign next_word_addr = addr_q + ADDR_WIDTH'(word_stride_q);

  // no address goes out while the generator is disabled
  assign addr_o       = addr_q;
  assign addr_valid_o = active_q & enable_i;
  assign done_o       = accept & last_addr;

  // pattern is captured once per job
  always_ff @(posedge clk_i) begin
    if (load) begin
      word_stride_q <= word_stride_i;
      line_length_q <= line_length_i;
      line_stride_q <= line_stride_i;
      tot_len_q     <= tot_len_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      word_cnt_q  <= '0;
      addr_cnt_q  <= '0;
      line_addr_q <= '0;
      addr_q      <= '0;
    end else if (clear_i) begin
      active_q    <= 1'b0;
      word_cnt_q  <= '0;
      addr_cnt_q  <= '0;
      line_addr_q <= '0;
      addr_q      <= '0;
    end else if (load) begin
      // an empty job never raises valid
      active_q    <= (tot_len_i != '0);
      word_cnt_q  <= '0;
      addr_cnt_q  <= '0;
      line_addr_q <= base_addr_i;
      addr_q      <= base_addr_i;
    end else if (accept) begin
      addr_cnt_q <= addr_cnt_q + LEN_WIDTH'(1);
      if (last_addr) begin
        active_q <= 1'b0;
      end
      if (line_wrap) begin
        // jump to the start of the next line
        word_cnt_q  <= '0;
        line_addr_q <= next_line_addr;
        addr_q      <= next_line_addr;
      end else begin
        word_cnt_q <= word_cnt_q + LEN_WIDTH'(1);
        addr_q     <= next_word_addr;
      end
    end
  end

endmodule

// File: design/core_sink.sv
// stream sink core: FSM, memory write request formation and completion tracking
`timescale 1ns/10ps

module core_sink import stream_cfg_pkg::*, sink_ctrl_pkg::*; #(
  parameter int unsigned DATA_WIDTH      = 32,
  parameter int unsigned TCDM_FIFO_DEPTH = 0,
  parameter int unsigned TRANS_CNT       = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  // control plane
  input  logic                    req_start_i,
  input  logic [ADDR_WIDTH-1:0]   base_addr_i,
  input  logic [STRIDE_WIDTH-1:0] word_stride_i,
  input  logic [LEN_WIDTH-1:0]    line_length_i,
  input  logic [STRIDE_WIDTH-1:0] line_stride_i,
  input  logic [LEN_WIDTH-1:0]    tot_len_i,
  output logic                    ready_start_o,
  output logic                    done_o,
  // input stream
  input  logic                    stream_valid_i,
  input  logic [DATA_WIDTH-1:0]   stream_data_i,
  input  logic [DATA_WIDTH/8-1:0] stream_strb_i,
  output logic                    stream_ready_o,
  // memory port
  output logic                    tcdm_req_o,
  output logic [ADDR_WIDTH-1:0]   tcdm_add_o,
  output logic [DATA_WIDTH-1:0]   tcdm_data_o,
  output logic [DATA_WIDTH/8-1:0] tcdm_be_o,
  input  logic                    tcdm_gnt_i
);

  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;
  localparam int unsigned ALIGN_BITS = $clog2(BE_WIDTH);
  localparam int unsigned REQ_WIDTH  = ADDR_WIDTH + DATA_WIDTH + BE_WIDTH;

  sink_state_e cs_q, ns;

  logic addr_gen_en;
  logic addr_gen_clr;
  logic addr_gen_start;
  logic addr_gen_done;

  logic [ADDR_WIDTH-1:0] gen_addr;
  logic                  gen_addr_valid;
  logic                  gen_addr_ready;

  logic [ADDR_WIDTH-1:0] addr_fifo_data;
  logic                  addr_fifo_valid;
  logic                  addr_fifo_pop;

  logic                  pre_req;
  logic [ADDR_WIDTH-1:0] pre_add;
  logic                  pre_gnt;

  logic                 done_d;
  logic                 cnt_clr;
  logic [TRANS_CNT-1:0] cnt_q;

  assign addr_gen_start = req_start_i & (cs_q == IDLE);

  stream_addressgen i_addressgen (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .clear_i       ( addr_gen_clr   ),
    .enable_i      ( addr_gen_en    ),
    .start_i       ( addr_gen_start ),
    .base_addr_i   ( base_addr_i    ),
    .word_stride_i ( word_stride_i  ),
    .line_length_i ( line_length_i  ),
    .line_stride_i ( line_stride_i  ),
    .tot_len_i     ( tot_len_i      ),
    .addr_ready_i  ( gen_addr_ready ),
    .addr_o        ( gen_addr       ),
    .addr_valid_o  ( gen_addr_valid ),
    .done_o        ( addr_gen_done  )
  );

  stream_fifo #(
    .WIDTH ( ADDR_WIDTH ),
    .DEPTH ( 2          )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( gen_addr_valid  ),
    .push_data_i  ( gen_addr        ),
    .push_ready_o ( gen_addr_ready  ),
    .pop_valid_o  ( addr_fifo_valid ),
    .pop_data_o   ( addr_fifo_data  ),
    .pop_ready_i  ( addr_fifo_pop   )
  );

  // one write per stream word, paired with the oldest pending address
  assign pre_req = (cs_q != IDLE) & stream_valid_i & addr_fifo_valid;
  assign pre_add = {addr_fifo_data[ADDR_WIDTH-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};

  // held low in idle so nothing is accepted before a job
  assign stream_ready_o = (cs_q != IDLE) & (~stream_valid_i | (pre_gnt & addr_fifo_valid));
  assign addr_fifo_pop  = stream_valid_i & stream_ready_o;

  if (TCDM_FIFO_DEPTH != 0) begin : gen_req_fifo
    logic [REQ_WIDTH-1:0] req_push;
    logic [REQ_WIDTH-1:0] req_pop;

    assign req_push = {pre_add, stream_data_i, stream_strb_i};

    stream_fifo #(
      .WIDTH ( REQ_WIDTH       ),
      .DEPTH ( TCDM_FIFO_DEPTH )
    ) i_req_fifo (
      .clk_i        ( clk_i      ),
      .rst_ni       ( rst_ni     ),
      .clear_i      ( clear_i    ),
      .push_valid_i ( pre_req    ),
      .push_data_i  ( req_push   ),
      .push_ready_o ( pre_gnt    ),
      .pop_valid_o  ( tcdm_req_o ),
      .pop_data_o   ( req_pop    ),
      .pop_ready_i  ( tcdm_gnt_i )
    );

    assign {tcdm_add_o, tcdm_data_o, tcdm_be_o} = req_pop;
  end else begin : gen_no_req_fifo
    assign tcdm_req_o  = pre_req;
    assign tcdm_add_o  = pre_add;
    assign tcdm_data_o = stream_data_i;
    assign tcdm_be_o   = stream_strb_i;
    assign pre_gnt     = tcdm_gnt_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q <= IDLE;
    end else if (clear_i) begin
      cs_q <= IDLE;
    end else begin
      cs_q <= ns;
    end
  end

  always_comb begin
    ns            = cs_q;
    done_d        = 1'b0;
    ready_start_o = 1'b0;
    addr_gen_en   = 1'b0;
    addr_gen_clr  = clear_i;
    cnt_clr       = 1'b0;
    case (cs_q)
      IDLE: begin
        ready_start_o = 1'b1;
        if (req_start_i) begin
          ns          = WORKING;
          addr_gen_en = 1'b1;
        end
      end
      WORKING: begin
        addr_gen_en = 1'b1;
        if (addr_gen_done) begin
          ns = DRAIN;
        end
      end
      DRAIN: begin
        addr_gen_en = 1'b1;
        // all addresses consumed by stream words
        if (cnt_q == TRANS_CNT'(tot_len_i)) begin
          ns           = IDLE;
          done_d       = 1'b1;
          addr_gen_en  = 1'b0;
          addr_gen_clr = 1'b1;
          cnt_clr      = 1'b1;
        end
      end
      default: begin
        ns = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || cnt_clr) begin
      cnt_q <= '0;
    end else if (addr_fifo_valid && addr_fifo_pop) begin
      cnt_q <= cnt_q + TRANS_CNT'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_o <= 1'b0;
    end else if (clear_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= done_d;
    end
  end

endmodule

// File: design/stream_sink_top.sv
// top level of the streaming memory write mover
`timescale 1ns/10ps

module stream_sink_top import stream_cfg_pkg::*, sink_ctrl_pkg::*; #(
  parameter int unsigned DATA_WIDTH      = 32,
  parameter int unsigned TCDM_FIFO_DEPTH = 0,
  parameter int unsigned TRANS_CNT       = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  // job control
  input  logic                    req_start_i,
  input  logic [ADDR_WIDTH-1:0]   base_addr_i,
  input  logic [STRIDE_WIDTH-1:0] word_stride_i,
  input  logic [LEN_WIDTH-1:0]    line_length_i,
  input  logic [STRIDE_WIDTH-1:0] line_stride_i,
  input  logic [LEN_WIDTH-1:0]    tot_len_i,
  output logic                    ready_start_o,
  output logic                    done_o,
  // input stream
  input  logic                    stream_valid_i,
  input  logic [DATA_WIDTH-1:0]   stream_data_i,
  input  logic [DATA_WIDTH/8-1:0] stream_strb_i,
  output logic                    stream_ready_o,
  // shared memory write port
  output logic                    tcdm_req_o,
  output logic [ADDR_WIDTH-1:0]   tcdm_add_o,
  output logic [DATA_WIDTH-1:0]   tcdm_data_o,
  output logic [DATA_WIDTH/8-1:0] tcdm_be_o,
  input  logic                    tcdm_gnt_i
);

  core_sink #(
    .DATA_WIDTH      ( DATA_WIDTH      ),
    .TCDM_FIFO_DEPTH ( TCDM_FIFO_DEPTH ),
    .TRANS_CNT       ( TRANS_CNT       )
  ) i_core_sink (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .req_start_i    ( req_start_i    ),
    .base_addr_i    ( base_addr_i    ),
    .word_stride_i  ( word_stride_i  ),
    .line_length_i  ( line_length_i  ),
    .line_stride_i  ( line_stride_i  ),
    .tot_len_i      ( tot_len_i      ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .stream_valid_i ( stream_valid_i ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .stream_ready_o ( stream_ready_o ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_add_o     ( tcdm_add_o     ),
    .tcdm_data_o    ( tcdm_data_o    ),
    .tcdm_be_o      ( tcdm_be_o      ),
    .tcdm_gnt_i     ( tcdm_gnt_i     )
  );

endmodule

// File: dv/stream_sink_checker.sv
// scoreboard for the stream sink: reference addresses, write comparison and per-test report
`timescale 1ns/10ps

module stream_sink_checker import stream_cfg_pkg::*, sink_ctrl_pkg::*; #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    req_start_i,
  input  logic [ADDR_WIDTH-1:0]   base_addr_i,
  input  logic [STRIDE_WIDTH-1:0] word_stride_i,
  input  logic [LEN_WIDTH-1:0]    line_length_i,
  input  logic [STRIDE_WIDTH-1:0] line_stride_i,
  input  logic [LEN_WIDTH-1:0]    tot_len_i,
  input  logic                    ready_start_i,
  input  logic                    done_i,
  input  logic                    stream_valid_i,
  input  logic [DATA_WIDTH-1:0]   stream_data_i,
  input  logic [DATA_WIDTH/8-1:0] stream_strb_i,
  input  logic                    stream_ready_i,
  input  logic                    tcdm_req_i,
  input  logic [ADDR_WIDTH-1:0]   tcdm_add_i,
  input  logic [DATA_WIDTH-1:0]   tcdm_data_i,
  input  logic [DATA_WIDTH/8-1:0] tcdm_be_i,
  input  logic                    tcdm_gnt_i,
  // test boundaries from the stimulus side
  input  logic                    test_end_i,
  input  int                      test_id_i,
  input  int                      exp_writes_i,
  input  int                      exp_done_i,
  output int                      err_cnt_o,
  output int                      failed_tests_o
);

  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  logic [ADDR_WIDTH-1:0]   cfg_base;
  logic [STRIDE_WIDTH-1:0] cfg_wstride;
  logic [LEN_WIDTH-1:0]    cfg_llen;
  logic [STRIDE_WIDTH-1:0] cfg_lstride;
  logic [LEN_WIDTH-1:0]    cfg_tot;

  // expected writes in stream order, oldest first
  logic [ADDR_WIDTH-1:0] exp_add_q [$];
  logic [DATA_WIDTH-1:0] exp_data_q [$];
  logic [BE_WIDTH-1:0]   exp_be_q [$];

  bit          busy;
  bit          done_prev;
  bit          clear_prev;
  int unsigned word_idx;
  int          writes_seen = 0;
  int          done_seen = 0;
  int          test_errs = 0;
  int          err_cnt = 0;
  int          failed_tests = 0;

  assign err_cnt_o      = err_cnt;
  assign failed_tests_o = failed_tests;

  // word k sits at column k mod line length of row k div line length
  function automatic logic [ADDR_WIDTH-1:0] ref_addr(
    input logic [ADDR_WIDTH-1:0]   base,
    input logic [STRIDE_WIDTH-1:0] wstride,
    input logic [LEN_WIDTH-1:0]    llen,
    input logic [STRIDE_WIDTH-1:0] lstride,
    input int unsigned             k
  );
    int unsigned           col;
    int unsigned           row;
    logic [ADDR_WIDTH-1:0] addr;
    col  = k % 32'(llen);
    row  = k / 32'(llen);
    addr = base + ADDR_WIDTH'(col) * ADDR_WIDTH'(wstride)
         + ADDR_WIDTH'(row) * ADDR_WIDTH'(lstride);
    // word aligned, byte offset bits dropped
    return addr & ~ADDR_WIDTH'(BE_WIDTH - 1);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    test_errs++;
    err_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("at %0t ns: %s", $time, msg);
    test_errs++;
    err_cnt++;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      busy       = 1'b0;
      done_prev  = 1'b0;
      clear_prev = 1'b0;
      word_idx   = 0;
      if (tcdm_req_i || stream_ready_i || done_i || !ready_start_i) begin
        report_failure("outputs are not at their reset values during reset");
      end
    end else begin
      // granted write against the oldest accepted stream word
      if (tcdm_req_i && exp_add_q.size() == 0) begin
        report_failure("memory request with no stream word behind it");
      end else if (tcdm_req_i && tcdm_gnt_i) begin
        if (tcdm_add_i !== exp_add_q[0]) begin
          report_mismatch($sformatf("address %h, expected %h", tcdm_add_i, exp_add_q[0]));
        end
        if (tcdm_data_i !== exp_data_q[0]) begin
          report_mismatch($sformatf("data %h, expected %h", tcdm_data_i, exp_data_q[0]));
        end
        if (tcdm_be_i !== exp_be_q[0]) begin
          report_mismatch($sformatf("byte enable %h, expected %h", tcdm_be_i, exp_be_q[0]));
        end
        void'(exp_add_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_be_q.pop_front());
        writes_seen++;
      end
      if (done_i) begin
        done_seen++;
        if (!busy) report_failure("done_o pulsed with no job running");
        if (done_prev) report_failure("done_o stayed high for more than one cycle");
        busy = 1'b0;
      end
      done_prev = done_i;
      if (clear_prev && !ready_start_i) begin
        report_failure("ready_start_o did not return after clear_i");
      end
      clear_prev = clear_i;
      if (clear_i) begin
        // pending words of the aborted job are dropped with the FIFOs
        busy = 1'b0;
        exp_add_q.delete();
        exp_data_q.delete();
        exp_be_q.delete();
      end else if (req_start_i && ready_start_i) begin
        cfg_base    = base_addr_i;
        cfg_wstride = word_stride_i;
        cfg_llen    = line_length_i;
        cfg_lstride = line_stride_i;
        cfg_tot     = tot_len_i;
        busy        = 1'b1;
        word_idx    = 0;
      end else if (busy && ready_start_i) begin
        report_failure("ready_start_o high while a job is running");
      end
      if (!clear_i && stream_valid_i && stream_ready_i) begin
        if (word_idx >= 32'(cfg_tot)) begin
          report_failure("stream word accepted beyond tot_len_i");
        end
        exp_add_q.push_back(ref_addr(cfg_base, cfg_wstride, cfg_llen, cfg_lstride, word_idx));
        exp_data_q.push_back(stream_data_i);
        exp_be_q.push_back(stream_strb_i);
        word_idx++;
      end
      if (test_end_i) begin
        if (writes_seen != exp_writes_i) begin
          report_mismatch($sformatf("%0d writes granted, expected %0d", writes_seen,
                                    exp_writes_i));
        end
        if (done_seen != exp_done_i) begin
          report_mismatch($sformatf("%0d done_o pulses, expected %0d", done_seen, exp_done_i));
        end
        if (exp_add_q.size() != 0) begin
          report_failure($sformatf("%0d stream words were never written", exp_add_q.size()));
        end
        $display("test %0d: %0d writes, %0d done pulses, %0d errors, %s", test_id_i,
                 writes_seen, done_seen, test_errs, (test_errs == 0) ? "ok" : "failed");
        if (test_errs != 0) failed_tests++;
        writes_seen = 0;
        done_seen   = 0;
        test_errs   = 0;
      end
    end
  end

endmodule

// File: dv/stream_sink_tb.sv
// testbench for the stream sink: clock, reset, stimulus, memory grant model and watchdog
`timescale 1ns/10ps

module stream_sink_tb
  import stream_cfg_pkg::*, sink_ctrl_pkg::*;
();

  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_W       = DATA_WIDTH / 8;
  localparam int          CLK_PERIOD = 20;
  localparam int          NUM_TESTS  = 5;
  // words per test, the aborted job of test 5 counted in full
  localparam int TOTAL_WORDS = 16 + 24 + 20 + (6 + 9) + (20 + 12);
  localparam int WATCHDOG_NS = (TOTAL_WORDS * 8 + NUM_TESTS * 50) * CLK_PERIOD;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    clear_i;
  logic                    req_start_i;
  logic [ADDR_WIDTH-1:0]   base_addr_i;
  logic [STRIDE_WIDTH-1:0] word_stride_i;
  logic [LEN_WIDTH-1:0]    line_length_i;
  logic [STRIDE_WIDTH-1:0] line_stride_i;
  logic [LEN_WIDTH-1:0]    tot_len_i;
  logic                    ready_start_o;
  logic                    done_o;
  logic                    stream_valid_i;
  logic [DATA_WIDTH-1:0]   stream_data_i;
  logic [BE_W-1:0]         stream_strb_i;
  logic                    stream_ready_o;
  logic                    tcdm_req_o;
  logic [ADDR_WIDTH-1:0]   tcdm_add_o;
  logic [DATA_WIDTH-1:0]   tcdm_data_o;
  logic [BE_W-1:0]         tcdm_be_o;
  logic                    tcdm_gnt_i = 1'b0;

  bit          gnt_random;
  logic        test_end;
  int          test_id;
  int          exp_writes;
  int          exp_done;
  int          err_cnt;
  int          failed_tests;

  stream_sink_top #(
    .DATA_WIDTH      ( DATA_WIDTH ),
    .TCDM_FIFO_DEPTH ( 4          ),
    .TRANS_CNT       ( 16         )
  ) DUT (
    .clk_i, .rst_ni, .clear_i, .req_start_i, .base_addr_i, .word_stride_i, .line_length_i,
    .line_stride_i, .tot_len_i, .ready_start_o, .done_o, .stream_valid_i, .stream_data_i,
    .stream_strb_i, .stream_ready_o, .tcdm_req_o, .tcdm_add_o, .tcdm_data_o, .tcdm_be_o,
    .tcdm_gnt_i
  );

  stream_sink_checker #(.DATA_WIDTH(DATA_WIDTH)) u_checker (
    .clk_i, .rst_ni, .clear_i, .req_start_i, .base_addr_i, .word_stride_i, .line_length_i,
    .line_stride_i, .tot_len_i, .ready_start_i(ready_start_o), .done_i(done_o),
    .stream_valid_i, .stream_data_i, .stream_strb_i, .stream_ready_i(stream_ready_o),
    .tcdm_req_i(tcdm_req_o), .tcdm_add_i(tcdm_add_o), .tcdm_data_i(tcdm_data_o),
    .tcdm_be_i(tcdm_be_o), .tcdm_gnt_i, .test_end_i(test_end), .test_id_i(test_id),
    .exp_writes_i(exp_writes), .exp_done_i(exp_done), .err_cnt_o(err_cnt),
    .failed_tests_o(failed_tests)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // memory model: grant always or with roughly 60 percent chance
  always @(negedge clk_i) begin
    if (!rst_ni) tcdm_gnt_i <= 1'b0;
    else if (gnt_random) tcdm_gnt_i <= ($urandom_range(99, 0) < 60);
    else tcdm_gnt_i <= 1'b1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic start_job(input logic [31:0] base, input logic [31:0] wstride,
                           input logic [15:0] llen, input logic [31:0] lstride,
                           input logic [15:0] tot);
    while (!ready_start_o) @(negedge clk_i);
    base_addr_i   = base;
    word_stride_i = wstride;
    line_length_i = llen;
    line_stride_i = lstride;
    tot_len_i     = tot;
    req_start_i   = 1'b1;
    @(negedge clk_i);
    req_start_i = 1'b0;
  endtask

  // valid stays up until ready was seen at a rising edge
  task automatic send_words(input int count, input int unsigned gap_pct, input bit rand_strb);
    int i;
    bit taken;
    for (i = 0; i < count; i++) begin
      while ($urandom_range(99, 0) < gap_pct) begin
        stream_valid_i = 1'b0;
        @(negedge clk_i);
      end
      stream_valid_i = 1'b1;
      stream_data_i  = DATA_WIDTH'({$urandom(), $urandom()});
      stream_strb_i  = rand_strb ? BE_W'($urandom()) : '1;
      do begin
        @(posedge clk_i);
        taken = stream_ready_o;
        @(negedge clk_i);
      end while (!taken);
    end
    stream_valid_i = 1'b0;
  endtask

  task automatic wait_done();
    do @(posedge clk_i); while (!done_o);
    @(negedge clk_i);
  endtask

  task automatic drain_writes();
    while (tcdm_req_o) @(negedge clk_i);
  endtask

  task automatic end_test(input int id, input int writes, input int dones);
    test_id    = id;
    exp_writes = writes;
    exp_done   = dones;
    test_end   = 1'b1;
    @(negedge clk_i);
    test_end = 1'b0;
  endtask

  initial begin
    void'($urandom(17581));
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    req_start_i    = 1'b0;
    base_addr_i    = '0;
    word_stride_i  = '0;
    line_length_i  = '0;
    line_stride_i  = '0;
    tot_len_i      = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    gnt_random     = 1'b0;
    test_end       = 1'b0;
    test_id        = 0;
    exp_writes     = 0;
    exp_done       = 0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // single line, full rate
    start_job(32'h1000_0000, 32'd4, 16'd16, 32'd0, 16'd16);
    send_words(16, 0, 1'b0);
    wait_done();
    drain_writes();
    end_test(1, 16, 1);

    // 2d pattern from an unaligned base with grant stalls
    gnt_random = 1'b1;
    start_job(32'h2000_0102, 32'd8, 16'd5, 32'h100, 16'd24);
    send_words(24, 0, 1'b0);
    wait_done();
    drain_writes();
    end_test(2, 24, 1);

    // stream gaps and random strobes
    start_job(32'h3000_0040, 32'd4, 16'd4, 32'h40, 16'd20);
    send_words(20, 40, 1'b1);
    wait_done();
    drain_writes();
    end_test(3, 20, 1);

    // back-to-back jobs, second one starts while writes are still queued
    start_job(32'h4000_0000, 32'd4, 16'd3, 32'h20, 16'd6);
    send_words(6, 10, 1'b0);
    wait_done();
    start_job(32'h4100_0000, 32'd12, 16'd9, 32'h200, 16'd9);
    send_words(9, 10, 1'b1);
    wait_done();
    drain_writes();
    end_test(4, 15, 2);

    // abort a job with clear_i, then run a fresh one
    gnt_random = 1'b0;
    start_job(32'h5000_0000, 32'd4, 16'd8, 32'h100, 16'd20);
    send_words(5, 0, 1'b0);
    drain_writes();
    repeat (3) @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    start_job(32'h5800_0000, 32'd4, 16'd6, 32'h80, 16'd12);
    send_words(12, 20, 1'b1);
    wait_done();
    drain_writes();
    end_test(5, 17, 1);

    repeat (2) @(negedge clk_i);
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, err_cnt);
    if (err_cnt == 0 && failed_tests == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: stream_sink.f
design/stream_cfg_pkg.sv
design/sink_ctrl_pkg.sv
design/stream_fifo.sv
design/stream_addressgen.sv
design/core_sink.sv
design/stream_sink_top.sv
dv/stream_sink_checker.sv
dv/stream_sink_tb.sv

// File: Makefile
# Verilator build and run of the stream sink testbench

VERILATOR ?= verilator
TOP       ?= stream_sink_tb
FILELIST  ?= stream_sink.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard design/*.sv dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
